// ==== source/exec_pkg.sv ====
package exec_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int DATA_W  = 24;
    localparam int ADDR_W  = 24;
    localparam int OPC_W   = 6;
    localparam int CC_W    = 4;
    localparam int GP_W    = 4;
    localparam int FLAG_W  = 4;
    // Enough to index any bit of a data word
    localparam int SHAMT_W = 5;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [OPC_W-1:0]  opc_t;
    typedef logic [CC_W-1:0]   cc_t;
    typedef logic [GP_W-1:0]   gp_idx_t;
    typedef logic [FLAG_W-1:0] flags_t;

    // Flag bit positions
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

    // ========================================================================
    // Opcodes
    // ========================================================================
    localparam opc_t OPC_NOP  = 6'h00;
    localparam opc_t OPC_MOV  = 6'h01;
    localparam opc_t OPC_ADD  = 6'h02;
    localparam opc_t OPC_SUB  = 6'h03;
    localparam opc_t OPC_NOT  = 6'h04;
    localparam opc_t OPC_AND  = 6'h05;
    localparam opc_t OPC_OR   = 6'h06;
    localparam opc_t OPC_XOR  = 6'h07;
    localparam opc_t OPC_SHL  = 6'h08;
    localparam opc_t OPC_SHR  = 6'h09;
    localparam opc_t OPC_CMP  = 6'h0a;
    localparam opc_t OPC_JCC  = 6'h0b;
    localparam opc_t OPC_LD   = 6'h0c;
    localparam opc_t OPC_ST   = 6'h0d;
    // Signed group
    localparam opc_t OPC_ADDS = 6'h11;
    localparam opc_t OPC_SUBS = 6'h12;
    localparam opc_t OPC_SHRS = 6'h13;
    localparam opc_t OPC_CMPS = 6'h14;

    // Codes outside this list are never taken
    localparam cc_t CC_RA = 4'h0;
    localparam cc_t CC_EQ = 4'h1;
    localparam cc_t CC_NE = 4'h2;
    localparam cc_t CC_LT = 4'h3;
    localparam cc_t CC_GT = 4'h4;
    localparam cc_t CC_GE = 4'h5;
    localparam cc_t CC_LE = 4'h6;
    localparam cc_t CC_BT = 4'h7;
    localparam cc_t CC_AT = 4'h8;
    localparam cc_t CC_BE = 4'h9;
    localparam cc_t CC_AE = 4'ha;

    // ========================================================================
    // Stage bundles
    // ========================================================================
    typedef struct packed {
        addr_t   pc;
        data_t   instr;
        opc_t    opc;
        gp_idx_t tgt_gp;
        logic    tgt_gp_we;
    } ex_ctrl_t;

    typedef struct packed {
        addr_t addr;
        data_t result;
    } ex_out_t;

endpackage

// ==== source/exec_alu.sv ====
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
    input  opc_t    opc,
    input  data_t   src_val,
    input  data_t   tgt_val,
    output ex_out_t alu_out,
    output flags_t  new_flags,
    output flags_t  flag_we
);

    logic [DATA_W:0]    sum_ext;
    data_t              diff;
    logic               add_ovf;
    logic               sub_ovf;
    logic               big_shift;
    logic [SHAMT_W-1:0] shamt;
    data_t              shl_res;
    data_t              shr_res;
    data_t              sra_res;

    // Z and N are taken from this word
    data_t              fval;
    logic               c_bit;
    logic               v_bit;

    // ========================================================================
    // Shared datapath
    // ========================================================================
    assign sum_ext = {1'b0, src_val} + {1'b0, tgt_val};
    assign diff    = tgt_val - src_val;

    // Two's-complement overflow on the sign bit
    assign add_ovf = ~(src_val[DATA_W-1] ^ tgt_val[DATA_W-1]) &
                     (src_val[DATA_W-1] ^ sum_ext[DATA_W-1]);
    assign sub_ovf = (tgt_val[DATA_W-1] ^ src_val[DATA_W-1]) &
                     (tgt_val[DATA_W-1] ^ diff[DATA_W-1]);

    // Whole src value is the amount
    assign big_shift = (src_val >= data_t'(DATA_W));
    assign shamt     = src_val[SHAMT_W-1:0];
    assign shl_res   = big_shift ? '0 : tgt_val << shamt;
    assign shr_res   = big_shift ? '0 : tgt_val >> shamt;
    assign sra_res   = big_shift ? '0 : data_t'($signed(tgt_val) >>> shamt);

    // ========================================================================
    // Opcode decode
    // ========================================================================
    always_comb begin
        alu_out = '0;
        fval    = '0;
        c_bit   = 1'b0;
        v_bit   = 1'b0;
        flag_we = '0;
        case (opc)
            OPC_MOV: alu_out.result = src_val;
            OPC_NOT: alu_out.result = ~tgt_val;
            OPC_AND: alu_out.result = src_val & tgt_val;
            OPC_OR:  alu_out.result = src_val | tgt_val;
            OPC_XOR: alu_out.result = src_val ^ tgt_val;
            OPC_ADD: begin
                alu_out.result = sum_ext[DATA_W-1:0];
                c_bit          = sum_ext[DATA_W];
            end
            OPC_SUB: begin
                alu_out.result = diff;
                c_bit          = (tgt_val < src_val);
            end
            OPC_SHL:  alu_out.result = shl_res;
            OPC_SHR:  alu_out.result = shr_res;
            OPC_SHRS: alu_out.result = sra_res;
            OPC_ADDS: begin
                alu_out.result = sum_ext[DATA_W-1:0];
                v_bit          = add_ovf;
            end
            OPC_SUBS: begin
                alu_out.result = diff;
                v_bit          = sub_ovf;
            end
            OPC_LD: alu_out.addr = src_val;
            OPC_ST: begin
                alu_out.addr   = tgt_val;
                alu_out.result = src_val;
            end
            default: ;
        endcase

        fval = alu_out.result;
        case (opc)
            OPC_MOV, OPC_NOT, OPC_AND, OPC_OR, OPC_XOR:
                flag_we[FLAG_Z] = 1'b1;
            OPC_ADD, OPC_SUB: begin
                flag_we[FLAG_Z] = 1'b1;
                flag_we[FLAG_C] = 1'b1;
            end
            OPC_CMP: begin
                fval            = diff;
                c_bit           = (tgt_val < src_val);
                flag_we[FLAG_Z] = 1'b1;
                flag_we[FLAG_C] = 1'b1;
            end
            OPC_SHL, OPC_SHR: begin
                v_bit           = big_shift;
                flag_we[FLAG_Z] = 1'b1;
                flag_we[FLAG_V] = 1'b1;
            end
            OPC_ADDS, OPC_SUBS, OPC_SHRS, OPC_CMPS: begin
                if (opc == OPC_SHRS)
                    v_bit = big_shift;
                if (opc == OPC_CMPS) begin
                    fval  = diff;
                    v_bit = sub_ovf;
                end
                flag_we[FLAG_Z] = 1'b1;
                flag_we[FLAG_N] = 1'b1;
                flag_we[FLAG_V] = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        new_flags         = '0;
        new_flags[FLAG_Z] = (fval == '0);
        new_flags[FLAG_N] = fval[DATA_W-1];
        new_flags[FLAG_C] = c_bit;
        new_flags[FLAG_V] = v_bit;
    end

endmodule

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; (
    input  logic   iw_clk,
    input  logic   iw_rst,
    input  opc_t   opc,
    input  addr_t  pc,
    input  cc_t    cc,
    input  data_t  src_val,
    input  flags_t new_flags,
    input  flags_t flag_we,
    input  logic   stall,
    output logic   branch_taken,
    output addr_t  branch_pc
);

    flags_t fl_q;
    logic   lt;
    logic   cond_ok;
    logic   is_jcc;

    // ========================================================================
    // Flag register
    // ========================================================================
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            fl_q <= '0;
        end else if (!stall) begin
            // Only the flags the instruction defines
            fl_q <= (fl_q & ~flag_we) | (new_flags & flag_we);
        end
    end

    // ========================================================================
    // Condition evaluation
    // ========================================================================
    assign lt     = fl_q[FLAG_N] ^ fl_q[FLAG_V];
    assign is_jcc = (opc == OPC_JCC) && !stall;

    always_comb begin
        case (cc)
            CC_RA:   cond_ok = 1'b1;
            CC_EQ:   cond_ok = fl_q[FLAG_Z];
            CC_NE:   cond_ok = ~fl_q[FLAG_Z];
            CC_LT:   cond_ok = lt;
            CC_GE:   cond_ok = ~lt;
            CC_GT:   cond_ok = ~fl_q[FLAG_Z] & ~lt;
            CC_LE:   cond_ok = fl_q[FLAG_Z] | lt;
            CC_BT:   cond_ok = fl_q[FLAG_C];
            CC_AE:   cond_ok = ~fl_q[FLAG_C];
            CC_AT:   cond_ok = ~fl_q[FLAG_C] & ~fl_q[FLAG_Z];
            CC_BE:   cond_ok = fl_q[FLAG_C] | fl_q[FLAG_Z];
            default: cond_ok = 1'b0;
        endcase
    end

    assign branch_taken = is_jcc & cond_ok;

    // Register-relative target
    assign branch_pc = branch_taken ? pc + addr_t'(src_val) : '0;

endmodule

// ==== source/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg import exec_pkg::*; (
    input  logic     iw_clk,
    input  logic     iw_rst,
    input  ex_ctrl_t ctrl,
    input  ex_out_t  alu_out,
    input  logic     stall,
    output ex_ctrl_t ctrl_q,
    output ex_out_t  out_q
);

    // ========================================================================
    // EX/MEM pipeline register
    // ========================================================================
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            ctrl_q <= '0;
            out_q  <= '0;
        end else if (!stall) begin
            ctrl_q <= ctrl;
            out_q  <= alu_out;
        end
    end

    // Downstream sees a frozen stage for every stalled cycle
    a_hold_on_stall: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        stall |=> ($stable(ctrl_q) && $stable(out_q))
    ) else $error("stage register changed under stall");

    // Write enable only ever accompanies a real instruction
    a_we_has_opc: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        ctrl_q.tgt_gp_we |-> (ctrl_q.opc != OPC_NOP)
    ) else $error("register write with NOP in EX/MEM");

endmodule

// ==== source/stg_ex.sv ====
`timescale 1ns/1ps

module stg_ex import exec_pkg::*; (
    input  logic     iw_clk,
    input  logic     iw_rst,
    input  ex_ctrl_t ctrl,
    input  cc_t      cc,
    input  data_t    src_val,
    input  data_t    tgt_val,
    input  logic     stall,
    output ex_ctrl_t ctrl_q,
    output ex_out_t  out_q,
    output logic     branch_taken,
    output addr_t    branch_pc
);

    ex_out_t alu_out;
    flags_t  new_flags;
    flags_t  flag_we;

    // ========================================================================
    // Datapath
    // ========================================================================
    exec_alu u_alu (
        .opc       (ctrl.opc),
        .src_val   (src_val),
        .tgt_val   (tgt_val),
        .alu_out   (alu_out),
        .new_flags (new_flags),
        .flag_we   (flag_we)
    );

    // Flags and jump resolution
    branch_unit u_branch (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .opc          (ctrl.opc),
        .pc           (ctrl.pc),
        .cc           (cc),
        .src_val      (src_val),
        .new_flags    (new_flags),
        .flag_we      (flag_we),
        .stall        (stall),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

    ex_mem_reg u_ex_mem (
        .iw_clk  (iw_clk),
        .iw_rst  (iw_rst),
        .ctrl    (ctrl),
        .alu_out (alu_out),
        .stall   (stall),
        .ctrl_q  (ctrl_q),
        .out_q   (out_q)
    );

endmodule

// ==== include/tb_stg_ex_tasks.svh ====
// ============================================================================
// Compare tasks
// ============================================================================
task automatic tally(input logic ok, input string name, input string got, input string exp);
    check_count++;
    if (!ok) begin
        err_count++;
        test_errs++;
        $display("[FAIL] %s got %s expected %s at %0t", name, got, exp, $time);
    end
endtask

task automatic check_data(input string name, input data_t got, input data_t exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic check_ctrl(input string name, input ex_ctrl_t got, input ex_ctrl_t exp);
    tally(got === exp, name, $sformatf("%h", got), $sformatf("%h", exp));
endtask

task automatic end_test(input string name);
    $display("%s: %0d error(s)", name, test_errs);
    test_errs = 0;
endtask

function automatic data_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[DATA_W-1:0];
endfunction

function automatic int rand_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r[15:0]) % n;
endfunction

// ============================================================================
// Drive
// ============================================================================
// Check the stage register, present the next instruction
// and then check the combinational branch outputs
task automatic step(input opc_t opc, input data_t s, input data_t t,
                    input cc_t c, input logic stl);
    ex_ctrl_t nc;
    logic     exp_taken;
    addr_t    exp_pc;
    @(negedge iw_clk);
    check_ctrl("ctrl_q", ctrl_q, exp_ctrl);
    check_addr("out_q.addr", out_q.addr, exp_out.addr);
    check_data("out_q.result", out_q.result, exp_out.result);
    nc.pc        = rand_word();
    nc.instr     = rand_word();
    nc.opc       = opc;
    nc.tgt_gp    = gp_idx_t'(rand_below(16));
    nc.tgt_gp_we = (opc != OPC_NOP) && (rand_below(2) == 1);
    ctrl    = nc;
    cc      = c;
    src_val = s;
    tgt_val = t;
    stall   = stl;
    #1;
    exp_taken = (opc == OPC_JCC) && !stl && model_cond(c, sh_flags);
    exp_pc    = exp_taken ? nc.pc + s : '0;
    check_bit("branch_taken", branch_taken, exp_taken);
    check_addr("branch_pc", branch_pc, exp_pc);
    if (!stl) begin
        sh_flags = model_flags(sh_flags, opc, s, t);
        exp_ctrl = nc;
        exp_out  = model_out(opc, s, t);
    end
endtask

task automatic issue(input opc_t opc, input data_t s, input data_t t);
    step(opc, s, t, cc_t'(rand_below(16)), 1'b0);
endtask

task automatic jump(input cc_t c);
    step(OPC_JCC, rand_word(), rand_word(), c, 1'b0);
endtask

// ============================================================================
// Tests
// ============================================================================
task automatic test_reset();
    ex_ctrl_t rc;
    data_t    s;
    iw_rst = 1'b1;
    for (int i = 0; i < RST_CYCLES; i++) begin
        @(negedge iw_clk);
        check_ctrl("ctrl_q", ctrl_q, '0);
        check_addr("out_q.addr", out_q.addr, '0);
        check_data("out_q.result", out_q.result, '0);
        check_bit("branch_taken", branch_taken, 1'b0);
        // Busy inputs that the reset has to mask
        s            = rand_word();
        rc.pc        = rand_word();
        rc.instr     = rand_word();
        rc.opc       = (i % 3 == 0) ? OPC_ST : ((i % 3 == 1) ? OPC_CMP : OPC_JCC);
        rc.tgt_gp    = gp_idx_t'(rand_below(16));
        rc.tgt_gp_we = 1'b1;
        ctrl    = rc;
        cc      = CC_EQ;
        src_val = s;
        tgt_val = (rc.opc == OPC_CMP) ? s : rand_word();
    end
    iw_rst  = 1'b0;
    ctrl    = '0;
    cc      = '0;
    src_val = '0;
    tgt_val = '0;
    // Z is clear out of reset
    issue(OPC_NOP, '0, '0);
    step(OPC_JCC, rand_word(), '0, CC_EQ, 1'b0);
    issue(OPC_NOP, '0, '0);
    end_test("reset");
endtask

task automatic test_unsigned();
    opc_t  ops [10] = '{OPC_MOV, OPC_ADD, OPC_SUB, OPC_NOT, OPC_AND,
                        OPC_OR, OPC_XOR, OPC_SHL, OPC_SHR, OPC_CMP};
    opc_t  op;
    data_t s;
    for (int i = 0; i < N_UNS; i++) begin
        op = ops[rand_below(10)];
        s  = (op == OPC_SHL || op == OPC_SHR) ? data_t'(rand_below(DATA_W)) : rand_word();
        issue(op, s, rand_word());
    end
    issue(OPC_NOP, '0, '0);
    end_test("unsigned ops");
endtask

task automatic test_signed_shifts();
    opc_t  sh_ops [3] = '{OPC_SHL, OPC_SHR, OPC_SHRS};
    data_t amts [4]   = '{24'd0, 24'd23, 24'd24, 24'hfffff0};
    opc_t  ar_ops [4] = '{OPC_ADDS, OPC_SUBS, OPC_ADDS, OPC_SUBS};
    data_t ar_src [4] = '{24'h000001, 24'h000001, 24'hfffffb, 24'h000005};
    data_t ar_tgt [4] = '{24'h7fffff, 24'h800000, 24'hfffffd, 24'h000003};
    for (int i = 0; i < 4; i++) begin
        issue(ar_ops[i], ar_src[i], ar_tgt[i]);
        jump(CC_LT);
        jump(CC_EQ);
    end
    for (int o = 0; o < 3; o++) begin
        for (int a = 0; a < 4; a++) begin
            issue(sh_ops[o], amts[a], 24'h8000a5);
            jump(CC_LT);
            jump(CC_EQ);
        end
    end
    issue(OPC_NOP, '0, '0);
    end_test("signed ops and shifts");
endtask

task automatic test_conditions();
    data_t s;
    data_t t;
    for (int p = 0; p < N_PAIRS; p++) begin
        s = rand_word();
        t = (p % 3 == 0) ? s : rand_word();
        issue((p % 2 == 0) ? OPC_CMP : OPC_CMPS, s, t);
        // Load writes no flags
        issue(OPC_LD, rand_word(), rand_word());
        for (int c = 0; c <= 10; c++)
            jump(cc_t'(c));
        jump(4'hf);
    end
    issue(OPC_NOP, '0, '0);
    end_test("conditions");
endtask

task automatic test_memory();
    for (int i = 0; i < 3; i++) begin
        issue(OPC_LD, rand_word(), rand_word());
        issue(OPC_ST, rand_word(), rand_word());
    end
    issue(OPC_NOP, '0, '0);
    end_test("memory ops");
endtask

task automatic test_stall();
    issue(OPC_ADD, 24'h000001, 24'h000002);
    // Equal operands would set Z if this compare got through
    step(OPC_CMP, 24'h000055, 24'h000055, CC_RA, 1'b1);
    step(OPC_MOV, 24'h0000aa, '0, CC_RA, 1'b1);
    step(OPC_JCC, 24'h000010, '0, CC_RA, 1'b1);
    step(OPC_JCC, 24'h000010, '0, CC_EQ, 1'b0);
    issue(OPC_NOP, '0, '0);
    end_test("stall");
endtask

// ==== bench/tb_stg_ex.sv ====
`timescale 1ns/1ps

module tb_stg_ex import exec_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 5;
    localparam int N_UNS      = 20;
    localparam int N_PAIRS    = 12;
    // Cycles issued by the six tests in order
    localparam int TEST_CYCLES = RST_CYCLES + 3 + (N_UNS + 1) + 49
                                 + (N_PAIRS * 14 + 1) + 7 + 6;
    localparam int TIMEOUT_NS  = TEST_CYCLES * CLK_PERIOD + 400;

    logic     iw_clk;
    logic     iw_rst;
    ex_ctrl_t ctrl;
    cc_t      cc;
    data_t    src_val;
    data_t    tgt_val;
    logic     stall;
    ex_ctrl_t ctrl_q;
    ex_out_t  out_q;
    logic     branch_taken;
    addr_t    branch_pc;

    integer   seed = 8;
    int       err_count;
    int       check_count;
    int       test_errs;

    // Shadow state of the reference model
    flags_t   sh_flags;
    ex_ctrl_t exp_ctrl;
    ex_out_t  exp_out;

    stg_ex uut (.*);

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic ex_out_t model_out(opc_t opc, data_t s, data_t t);
        ex_out_t o;
        o = '0;
        case (opc)
            OPC_MOV:           o.result = s;
            OPC_ADD, OPC_ADDS: o.result = t + s;
            OPC_SUB, OPC_SUBS: o.result = t - s;
            OPC_NOT:           o.result = ~t;
            OPC_AND:           o.result = t & s;
            OPC_OR:            o.result = t | s;
            OPC_XOR:           o.result = t ^ s;
            OPC_SHL:           o.result = (int'(s) < DATA_W) ? t << s : '0;
            OPC_SHR:           o.result = (int'(s) < DATA_W) ? t >> s : '0;
            OPC_SHRS:          o.result = (int'(s) < DATA_W) ? data_t'($signed(t) >>> s) : '0;
            OPC_LD:            o.addr = s;
            OPC_ST: begin
                o.addr   = t;
                o.result = s;
            end
            default: ;
        endcase
        return o;
    endfunction

    function automatic flags_t model_flags(flags_t f, opc_t opc, data_t s, data_t t);
        ex_out_t o;
        data_t   res;
        int      wide;
        logic    ovf;
        flags_t  nf;
        nf  = f;
        o   = model_out(opc, s, t);
        res = (opc == OPC_CMP || opc == OPC_CMPS) ? t - s : o.result;
        // Signed sum or difference in full integer range
        if (opc == OPC_ADDS)
            wide = int'($signed(t)) + int'($signed(s));
        else
            wide = int'($signed(t)) - int'($signed(s));
        ovf = (wide >= (1 << (DATA_W - 1))) || (wide < -(1 << (DATA_W - 1)));
        case (opc)
            OPC_MOV, OPC_NOT, OPC_AND, OPC_OR, OPC_XOR:
                nf[FLAG_Z] = (res == '0);
            OPC_ADD: begin
                nf[FLAG_Z] = (res == '0);
                nf[FLAG_C] = (int'(t) + int'(s)) >= (1 << DATA_W);
            end
            OPC_SUB, OPC_CMP: begin
                nf[FLAG_Z] = (res == '0);
                nf[FLAG_C] = (t < s);
            end
            OPC_SHL, OPC_SHR: begin
                nf[FLAG_Z] = (res == '0);
                nf[FLAG_V] = (int'(s) >= DATA_W);
            end
            OPC_ADDS, OPC_SUBS, OPC_SHRS, OPC_CMPS: begin
                nf[FLAG_Z] = (res == '0);
                nf[FLAG_N] = res[DATA_W-1];
                nf[FLAG_V] = (opc == OPC_SHRS) ? (int'(s) >= DATA_W) : ovf;
            end
            default: ;
        endcase
        return nf;
    endfunction

    function automatic logic model_cond(cc_t c, flags_t f);
        logic lt;
        logic r;
        lt = f[FLAG_N] ^ f[FLAG_V];
        case (c)
            CC_RA:   r = 1'b1;
            CC_EQ:   r = f[FLAG_Z];
            CC_NE:   r = !f[FLAG_Z];
            CC_LT:   r = lt;
            CC_GE:   r = !lt;
            CC_GT:   r = !f[FLAG_Z] && !lt;
            CC_LE:   r = f[FLAG_Z] || lt;
            CC_BT:   r = f[FLAG_C];
            CC_AE:   r = !f[FLAG_C];
            CC_AT:   r = !f[FLAG_C] && !f[FLAG_Z];
            CC_BE:   r = f[FLAG_C] || f[FLAG_Z];
            default: r = 1'b0;
        endcase
        return r;
    endfunction

    `include "tb_stg_ex_tasks.svh"

    initial iw_clk = 1'b0;
    always #(CLK_PERIOD / 2) iw_clk = ~iw_clk;

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        err_count   = 0;
        check_count = 0;
        test_errs   = 0;
        iw_rst      = 1'b1;
        ctrl        = '0;
        cc          = '0;
        src_val     = '0;
        tgt_val     = '0;
        stall       = 1'b0;
        sh_flags    = '0;
        exp_ctrl    = '0;
        exp_out     = '0;
        test_reset();
        test_unsigned();
        test_signed_shifts();
        test_conditions();
        test_memory();
        test_stall();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
source/exec_pkg.sv
source/exec_alu.sv
source/branch_unit.sv
source/ex_mem_reg.sv
source/stg_ex.sv
bench/tb_stg_ex.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the EX stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_stg_ex \
    -f compile.f -o tb_stg_ex
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_stg_ex > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
